// ==== verilog.f ====
source/mcu_pkg.sv
source/op_controller.sv
source/bram_reader.sv
source/stream_fifo.sv
source/mcu_top.sv
sim/bram_model.sv
sim/mcu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module mcu_tb \
  --Mdir obj_dir \
  -o mcu_tb_sim \
  -f verilog.f

./obj_dir/mcu_tb_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without a reported failure"

// ==== sim/mcu_tb.sv ====
module mcu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 5;
  // Legal words over all runs with random runs counted at their largest
  localparam int SIZE_SUM = 10 + 5 * 120 + 12 + 264 + 98;
  localparam int CYCLE_LIMIT = SIZE_SUM * 4 + 200 * NUM_TESTS;
  localparam int RUN_OK     = 0;
  localparam int RUN_REJECT = 1;
  localparam int RUN_FAULT  = 2;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        operation_start;
  logic [mcu_pkg::SIZE_W-1:0]  data_size;
  logic [mcu_pkg::SIZE_W-1:0]  grid_size;
  logic [mcu_pkg::SIZE_W-1:0]  scle_size;
  logic                        operation_in_progress;
  logic                        operation_complete;
  logic                        operation_error;
  logic                        data_bram_en, grid_bram_en, scle_bram_en;
  logic [mcu_pkg::ADDR_W-1:0]  data_bram_addr, grid_bram_addr, scle_bram_addr;
  logic [mcu_pkg::DATA_W-1:0]  data_rddata, grid_rddata;
  logic [mcu_pkg::SCALE_W-1:0] scle_rddata;
  logic                        data_rdvalid, grid_rdvalid, scle_rdvalid;
  logic                        grid_inject;
  logic [mcu_pkg::DATA_W-1:0]  data_tdata, grid_tdata;
  logic [mcu_pkg::SCALE_W-1:0] scle_tdata;
  logic                        data_tvalid, grid_tvalid, scle_tvalid;
  logic                        data_tready, grid_tready, scle_tready;
  logic                        data_tlast, grid_tlast, scle_tlast;

  // Per-stream state indexed by stream number (data 0, grid 1, scale 2)
  int exp_size [3];
  int run_base [3];
  int beat_cnt [3];
  int valid_cnt [3];
  int valid_base [3];
  int beat_errs [3];
  int complete_total;
  int error_total;
  int check_errs;
  int cycles;
  int tests_passed;
  int tests_failed;
  bit rand_ready;
  bit hold_grid;

  always #10 clk = ~clk;

  mcu_top u_dut (
    .clk(clk), .rst(rst), .operation_start(operation_start),
    .data_size(data_size), .grid_size(grid_size), .scle_size(scle_size),
    .operation_in_progress(operation_in_progress),
    .operation_complete(operation_complete), .operation_error(operation_error),
    .data_bram_en(data_bram_en), .data_bram_addr(data_bram_addr),
    .data_bram_rddata(data_rddata), .data_bram_rdvalid(data_rdvalid),
    .grid_bram_en(grid_bram_en), .grid_bram_addr(grid_bram_addr),
    .grid_bram_rddata(grid_rddata), .grid_bram_rdvalid(grid_rdvalid),
    .scle_bram_en(scle_bram_en), .scle_bram_addr(scle_bram_addr),
    .scle_bram_rddata(scle_rddata), .scle_bram_rdvalid(scle_rdvalid),
    .m_axis_data_tdata(data_tdata), .m_axis_data_tvalid(data_tvalid),
    .m_axis_data_tready(data_tready), .m_axis_data_tlast(data_tlast),
    .m_axis_grid_tdata(grid_tdata), .m_axis_grid_tvalid(grid_tvalid),
    .m_axis_grid_tready(grid_tready), .m_axis_grid_tlast(grid_tlast),
    .m_axis_scle_tdata(scle_tdata), .m_axis_scle_tvalid(scle_tvalid),
    .m_axis_scle_tready(scle_tready), .m_axis_scle_tlast(scle_tlast)
  );

  bram_model #(.KEY(16'h1234), .WIDTH(mcu_pkg::DATA_W)) u_mem_data (
    .clk(clk), .rst(rst), .bram_en(data_bram_en), .bram_addr(data_bram_addr),
    .inject(1'b0), .rddata(data_rddata), .rdvalid(data_rdvalid)
  );

  bram_model #(.KEY(16'hA5C3), .WIDTH(mcu_pkg::DATA_W)) u_mem_grid (
    .clk(clk), .rst(rst), .bram_en(grid_bram_en), .bram_addr(grid_bram_addr),
    .inject(grid_inject), .rddata(grid_rddata), .rdvalid(grid_rdvalid)
  );

  bram_model #(.KEY(16'h005A), .WIDTH(mcu_pkg::SCALE_W)) u_mem_scle (
    .clk(clk), .rst(rst), .bram_en(scle_bram_en), .bram_addr(scle_bram_addr),
    .inject(1'b0), .rddata(scle_rddata), .rdvalid(scle_rdvalid)
  );

  // Word at address a is {a, a} XOR key cut to the stream width
  function automatic logic [15:0] expected_word(input int s, input int idx);
    logic [7:0]  a;
    logic [15:0] word;
    a = idx[7:0];
    word = {a, a};
    case (s)
      0: word = word ^ 16'h1234;
      1: word = word ^ 16'hA5C3;
      default: word = {8'h00, word[7:0] ^ 8'h5A};
    endcase
    return word;
  endfunction

  function automatic string stream_name(input int s);
    case (s)
      0: return "data";
      1: return "grid";
      default: return "scle";
    endcase
  endfunction

  function automatic int total_errors();
    return check_errs + beat_errs[0] + beat_errs[1] + beat_errs[2];
  endfunction

  task automatic report_problem(input string msg);
    $display("%s", msg);
    check_errs = check_errs + 1;
  endtask

  task automatic check_beat(input int s, input logic [15:0] data, input logic last);
    int          idx;
    logic [15:0] want;
    logic        want_last;
    idx = beat_cnt[s] - run_base[s];
    want = expected_word(s, idx);
    want_last = (idx == exp_size[s] - 1);
    if (idx >= exp_size[s]) begin
      $display("Stream %s sent word %0d past its size of %0d", stream_name(s), idx,
               exp_size[s]);
      beat_errs[s] = beat_errs[s] + 1;
    end else begin
      if (data !== want) begin
        $display("** Error: m_axis_%s_tdata at index %0d is 0x%h, expected 0x%h",
                 stream_name(s), idx, data, want);
        beat_errs[s] = beat_errs[s] + 1;
      end
      if (last !== want_last) begin
        $display("** Error: m_axis_%s_tlast at index %0d is 0x%h, expected 0x%h",
                 stream_name(s), idx, last, want_last);
        beat_errs[s] = beat_errs[s] + 1;
      end
    end
    beat_cnt[s] = beat_cnt[s] + 1;
  endtask

  // One comparator per stream
  always @(posedge clk) begin
    if (!rst && data_tvalid) begin
      valid_cnt[0] = valid_cnt[0] + 1;
      if (data_tready) begin
        check_beat(0, data_tdata, data_tlast);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && grid_tvalid) begin
      valid_cnt[1] = valid_cnt[1] + 1;
      if (grid_tready) begin
        check_beat(1, grid_tdata, grid_tlast);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && scle_tvalid) begin
      valid_cnt[2] = valid_cnt[2] + 1;
      if (scle_tready) begin
        check_beat(2, {8'h00, scle_tdata}, scle_tlast);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && operation_complete) begin
      complete_total = complete_total + 1;
    end
    if (!rst && operation_error) begin
      error_total = error_total + 1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a run never finished", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // Sink side back-pressure
  initial begin
    data_tready = 1'b1;
    grid_tready = 1'b1;
    scle_tready = 1'b1;
    forever begin
      @(negedge clk);
      data_tready = rand_ready ? (($urandom % 2) == 0) : 1'b1;
      grid_tready = hold_grid ? 1'b0 : (rand_ready ? (($urandom % 2) == 0) : 1'b1);
      scle_tready = rand_ready ? (($urandom % 2) == 0) : 1'b1;
    end
  end

  task automatic run_op(input int ds, input int gs, input int ss, input int mode);
    int i;
    int complete_base;
    int error_base;
    exp_size[0] = ds;
    exp_size[1] = gs;
    exp_size[2] = ss;
    for (i = 0; i < 3; i++) begin
      run_base[i] = beat_cnt[i];
      valid_base[i] = valid_cnt[i];
    end
    complete_base = complete_total;
    error_base = error_total;
    @(negedge clk);
    data_size = ds[mcu_pkg::SIZE_W-1:0];
    grid_size = gs[mcu_pkg::SIZE_W-1:0];
    scle_size = ss[mcu_pkg::SIZE_W-1:0];
    operation_start = 1'b1;
    @(negedge clk);
    operation_start = 1'b0;
    if (mode == RUN_REJECT && operation_in_progress) begin
      report_problem("operation_in_progress rose for a run with illegal sizes");
    end
    if (mode != RUN_REJECT && !operation_in_progress) begin
      report_problem("operation_in_progress was low the cycle after operation_start");
    end
    while (complete_total == complete_base && error_total == error_base) begin
      @(negedge clk);
    end
    // Room for a second pulse or a stray word to show
    repeat (4) @(negedge clk);
    if (mode == RUN_OK) begin
      if (complete_total - complete_base != 1) begin
        report_problem($sformatf("operation_complete pulsed %0d times",
                                 complete_total - complete_base));
      end
      if (error_total != error_base) begin
        report_problem("operation_error pulsed during a legal run");
      end
      for (i = 0; i < 3; i++) begin
        if (beat_cnt[i] - run_base[i] != exp_size[i]) begin
          report_problem($sformatf("Stream %s delivered %0d of %0d words", stream_name(i),
                                   beat_cnt[i] - run_base[i], exp_size[i]));
        end
      end
    end else begin
      if (error_total - error_base != 1) begin
        report_problem($sformatf("operation_error pulsed %0d times instead of once",
                                 error_total - error_base));
      end
      if (complete_total != complete_base) begin
        report_problem("operation_complete pulsed during a failed run");
      end
    end
    if (mode == RUN_REJECT) begin
      for (i = 0; i < 3; i++) begin
        if (valid_cnt[i] != valid_base[i]) begin
          report_problem($sformatf("Stream %s raised tvalid on a rejected run",
                                   stream_name(i)));
        end
      end
    end
    if (operation_in_progress) begin
      report_problem("operation_in_progress still high after the run ended");
    end
  endtask

  // The extra answer is unsolicited once the grid buffer fills with no read outstanding
  task automatic inject_grid_fault();
    @(negedge clk);
    while (!(grid_tvalid && !grid_bram_en && !grid_rdvalid)) begin
      @(negedge clk);
    end
    if (!operation_in_progress) begin
      report_problem("Run was not in progress when the grid fault was injected");
    end
    grid_inject = 1'b1;
    @(negedge clk);
    grid_inject = 1'b0;
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    if (errs == 0) begin
      tests_passed = tests_passed + 1;
      $display("Test %0d %s: PASS", num, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %0d %s: FAIL with %0d errors", num, name, errs);
    end
  endtask

  initial begin
    int k;
    int errs_before;
    rst = 1'b1;
    operation_start = 1'b0;
    data_size = '0;
    grid_size = '0;
    scle_size = '0;
    grid_inject = 1'b0;
    rand_ready = 1'b0;
    hold_grid = 1'b0;
    void'($urandom(32'h8495_2bfc));
    repeat (3) @(negedge clk);
    rst = 1'b0;

    errs_before = total_errors();
    run_op(5, 3, 2, RUN_OK);
    end_test(1, "basic run", errs_before);

    errs_before = total_errors();
    rand_ready = 1'b1;
    for (k = 0; k < 5; k++) begin
      run_op(int'($urandom_range(40, 1)), int'($urandom_range(40, 1)),
             int'($urandom_range(40, 1)), RUN_OK);
    end
    end_test(2, "random sizes and ready", errs_before);

    errs_before = total_errors();
    rand_ready = 1'b0;
    run_op(4, 0, 3, RUN_REJECT);
    run_op(6, 5, 300, RUN_REJECT);
    run_op(4, 4, 4, RUN_OK);
    end_test(3, "illegal sizes", errs_before);

    errs_before = total_errors();
    rand_ready = 1'b1;
    run_op(256, 5, 3, RUN_OK);
    end_test(4, "full memory", errs_before);

    errs_before = total_errors();
    rand_ready = 1'b0;
    hold_grid = 1'b1;
    fork
      run_op(30, 20, 30, RUN_FAULT);
      inject_grid_fault();
    join
    hold_grid = 1'b0;
    run_op(6, 6, 6, RUN_OK);
    end_test(5, "fault injection", errs_before);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim/bram_model.sv ====
module bram_model #(
  parameter logic [15:0] KEY   = 16'h0000,
  parameter int          WIDTH = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       bram_en,
  input  logic [mcu_pkg::ADDR_W-1:0] bram_addr,
  input  logic                       inject,
  output logic [WIDTH-1:0]           rddata,
  output logic                       rdvalid
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0] word;

  // Address times 0x0101, scrambled by the key
  assign word = ({8'd0, bram_addr} * 16'h0101) ^ KEY;

  // One cycle read latency; inject adds an answer nobody asked for
  always_ff @(posedge clk) begin
    if (rst) begin
      rdvalid <= 1'b0;
      rddata  <= '0;
    end else begin
      rdvalid <= bram_en || inject;
      rddata  <= word[WIDTH-1:0];
    end
  end

endmodule

// ==== source/mcu_top.sv ====
module mcu_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        operation_start,
  input  logic [mcu_pkg::SIZE_W-1:0]  data_size,
  input  logic [mcu_pkg::SIZE_W-1:0]  grid_size,
  input  logic [mcu_pkg::SIZE_W-1:0]  scle_size,
  output logic                        operation_in_progress,
  output logic                        operation_complete,
  output logic                        operation_error,
  output logic                        data_bram_en,
  output logic [mcu_pkg::ADDR_W-1:0]  data_bram_addr,
  input  logic [mcu_pkg::DATA_W-1:0]  data_bram_rddata,
  input  logic                        data_bram_rdvalid,
  output logic                        grid_bram_en,
  output logic [mcu_pkg::ADDR_W-1:0]  grid_bram_addr,
  input  logic [mcu_pkg::DATA_W-1:0]  grid_bram_rddata,
  input  logic                        grid_bram_rdvalid,
  output logic                        scle_bram_en,
  output logic [mcu_pkg::ADDR_W-1:0]  scle_bram_addr,
  input  logic [mcu_pkg::SCALE_W-1:0] scle_bram_rddata,
  input  logic                        scle_bram_rdvalid,
  output logic [mcu_pkg::DATA_W-1:0]  m_axis_data_tdata,
  output logic                        m_axis_data_tvalid,
  input  logic                        m_axis_data_tready,
  output logic                        m_axis_data_tlast,
  output logic [mcu_pkg::DATA_W-1:0]  m_axis_grid_tdata,
  output logic                        m_axis_grid_tvalid,
  input  logic                        m_axis_grid_tready,
  output logic                        m_axis_grid_tlast,
  output logic [mcu_pkg::SCALE_W-1:0] m_axis_scle_tdata,
  output logic                        m_axis_scle_tvalid,
  input  logic                        m_axis_scle_tready,
  output logic                        m_axis_scle_tlast
);

  logic                        start;
  logic                        abort;
  logic [mcu_pkg::SIZE_W-1:0]  data_len, grid_len, scle_len;
  logic                        data_err, grid_err, scle_err;
  logic                        data_last_sent, grid_last_sent, scle_last_sent;
  logic                        data_push, grid_push, scle_push;
  logic                        data_push_last, grid_push_last, scle_push_last;
  logic [mcu_pkg::CNT_W-1:0]   data_free, grid_free, scle_free;
  logic [mcu_pkg::DATA_W-1:0]  data_push_data, grid_push_data;
  logic [mcu_pkg::SCALE_W-1:0] scle_push_data;

  op_controller u_ctrl (
    .clk(clk), .rst(rst),
    .operation_start(operation_start),
    .data_size(data_size), .grid_size(grid_size), .scle_size(scle_size),
    .err_data(data_err), .err_grid(grid_err), .err_scle(scle_err),
    .last_data(data_last_sent), .last_grid(grid_last_sent), .last_scle(scle_last_sent),
    .start(start), .abort(abort),
    .len_data(data_len), .len_grid(grid_len), .len_scle(scle_len),
    .operation_in_progress(operation_in_progress),
    .operation_complete(operation_complete),
    .operation_error(operation_error)
  );

  // Data path
  bram_reader #(.payload_t(logic [mcu_pkg::DATA_W-1:0])) u_rd_data (
    .clk(clk), .rst(rst), .start(start), .abort(abort), .len(data_len),
    .bram_en(data_bram_en), .bram_addr(data_bram_addr),
    .bram_rddata(data_bram_rddata), .bram_rdvalid(data_bram_rdvalid),
    .free(data_free), .push(data_push), .push_data(data_push_data),
    .push_last(data_push_last), .err(data_err)
  );

  stream_fifo #(.payload_t(logic [mcu_pkg::DATA_W-1:0])) u_fifo_data (
    .clk(clk), .rst(rst), .flush(abort),
    .push(data_push), .push_data(data_push_data), .push_last(data_push_last),
    .free(data_free), .tdata(m_axis_data_tdata), .tvalid(m_axis_data_tvalid),
    .tready(m_axis_data_tready), .tlast(m_axis_data_tlast), .last_sent(data_last_sent)
  );

  // Grid path
  bram_reader #(.payload_t(logic [mcu_pkg::DATA_W-1:0])) u_rd_grid (
    .clk(clk), .rst(rst), .start(start), .abort(abort), .len(grid_len),
    .bram_en(grid_bram_en), .bram_addr(grid_bram_addr),
    .bram_rddata(grid_bram_rddata), .bram_rdvalid(grid_bram_rdvalid),
    .free(grid_free), .push(grid_push), .push_data(grid_push_data),
    .push_last(grid_push_last), .err(grid_err)
  );

  stream_fifo #(.payload_t(logic [mcu_pkg::DATA_W-1:0])) u_fifo_grid (
    .clk(clk), .rst(rst), .flush(abort),
    .push(grid_push), .push_data(grid_push_data), .push_last(grid_push_last),
    .free(grid_free), .tdata(m_axis_grid_tdata), .tvalid(m_axis_grid_tvalid),
    .tready(m_axis_grid_tready), .tlast(m_axis_grid_tlast), .last_sent(grid_last_sent)
  );

  // Scale path, narrower words
  bram_reader #(.payload_t(logic [mcu_pkg::SCALE_W-1:0])) u_rd_scle (
    .clk(clk), .rst(rst), .start(start), .abort(abort), .len(scle_len),
    .bram_en(scle_bram_en), .bram_addr(scle_bram_addr),
    .bram_rddata(scle_bram_rddata), .bram_rdvalid(scle_bram_rdvalid),
    .free(scle_free), .push(scle_push), .push_data(scle_push_data),
    .push_last(scle_push_last), .err(scle_err)
  );

  stream_fifo #(.payload_t(logic [mcu_pkg::SCALE_W-1:0])) u_fifo_scle (
    .clk(clk), .rst(rst), .flush(abort),
    .push(scle_push), .push_data(scle_push_data), .push_last(scle_push_last),
    .free(scle_free), .tdata(m_axis_scle_tdata), .tvalid(m_axis_scle_tvalid),
    .tready(m_axis_scle_tready), .tlast(m_axis_scle_tlast), .last_sent(scle_last_sent)
  );

endmodule

// ==== source/stream_fifo.sv ====
module stream_fifo #(
  parameter type payload_t = logic [15:0]
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush,
  input  logic                      push,
  input  payload_t                  push_data,
  input  logic                      push_last,
  output logic [mcu_pkg::CNT_W-1:0] free,
  output payload_t                  tdata,
  output logic                      tvalid,
  input  logic                      tready,
  output logic                      tlast,
  output logic                      last_sent
);

  // Word and its last flag kept side by side
  typedef struct packed {
    logic     last;
    payload_t data;
  } entry_t;

  entry_t                                 mem [mcu_pkg::FIFO_DEPTH];
  logic [$clog2(mcu_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(mcu_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic [mcu_pkg::CNT_W-1:0]              count;
  logic                                   pop;

  // Head entry shows directly on the stream
  assign tvalid    = (count != '0);
  assign tdata     = mem[rd_ptr].data;
  assign tlast     = mem[rd_ptr].last;
  assign pop       = tvalid && tready;
  assign last_sent = pop && tlast;
  assign free      = mcu_pkg::FIFO_DEPTH - count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{last: push_last, data: push_data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // Reader credit must keep writes away from a full buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> (free != '0));

endmodule

// ==== source/bram_reader.sv ====
module bram_reader #(
  parameter type payload_t = logic [15:0]
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       abort,
  input  logic [mcu_pkg::SIZE_W-1:0] len,
  output logic                       bram_en,
  output logic [mcu_pkg::ADDR_W-1:0] bram_addr,
  input  payload_t                   bram_rddata,
  input  logic                       bram_rdvalid,
  input  logic [mcu_pkg::CNT_W-1:0]  free,
  output logic                       push,
  output payload_t                   push_data,
  output logic                       push_last,
  output logic                       err
);

  logic                       active;
  // Addresses sent to the memory
  logic [mcu_pkg::SIZE_W-1:0] issued;
  // Words handed to the buffer
  logic [mcu_pkg::SIZE_W-1:0] returned;
  // Reads sent but not yet answered
  logic [mcu_pkg::CNT_W-1:0]  inflight;

  // One more read only if every outstanding read already has a slot
  assign bram_en   = active && (issued != len) && (free > inflight);
  assign bram_addr = issued[mcu_pkg::ADDR_W-1:0];

  // Answers come back in order and go straight to the buffer
  assign push      = bram_rdvalid && (inflight != '0);
  assign push_data = bram_rddata;
  assign push_last = push && ((returned + 1'b1) == len);

  // Answer with nothing outstanding means the memory misbehaved
  assign err = bram_rdvalid && (inflight == '0);

  always_ff @(posedge clk) begin
    if (rst || abort) begin
      active   <= 1'b0;
      issued   <= '0;
      returned <= '0;
      inflight <= '0;
    end else begin
      if (start) begin
        active   <= 1'b1;
        issued   <= '0;
        returned <= '0;
      end else begin
        if (bram_en) begin
          issued <= issued + 1'b1;
        end
        if (push) begin
          returned <= returned + 1'b1;
        end
        // Done once the final word is in the buffer
        if (push_last) begin
          active <= 1'b0;
        end
      end
      case ({bram_en, push})
        2'b10: begin
          inflight <= inflight + 1'b1;
        end
        2'b01: begin
          inflight <= inflight - 1'b1;
        end
        default: begin
          inflight <= inflight;
        end
      endcase
    end
  end

  // A new run finds the reader idle with no reads outstanding
  a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> (!active && (inflight == '0)));

endmodule

// ==== source/op_controller.sv ====
module op_controller (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       operation_start,
  input  logic [mcu_pkg::SIZE_W-1:0] data_size,
  input  logic [mcu_pkg::SIZE_W-1:0] grid_size,
  input  logic [mcu_pkg::SIZE_W-1:0] scle_size,
  input  logic                       err_data,
  input  logic                       err_grid,
  input  logic                       err_scle,
  input  logic                       last_data,
  input  logic                       last_grid,
  input  logic                       last_scle,
  output logic                       start,
  output logic                       abort,
  output logic [mcu_pkg::SIZE_W-1:0] len_data,
  output logic [mcu_pkg::SIZE_W-1:0] len_grid,
  output logic [mcu_pkg::SIZE_W-1:0] len_scle,
  output logic                       operation_in_progress,
  output logic                       operation_complete,
  output logic                       operation_error
);

  mcu_pkg::glo_state_t state;
  mcu_pkg::glo_state_t state_next;

  // Sticky end-of-stream flags with scle in the top bit and data in bit 0
  logic [2:0] done;
  logic       sizes_ok;
  logic       any_err;
  logic       running;

  // Legal range is 1 to MAX_LEN
  function automatic logic size_ok(input logic [mcu_pkg::SIZE_W-1:0] size);
    return (size != '0) && (size <= mcu_pkg::MAX_LEN);
  endfunction

  assign sizes_ok = size_ok(data_size) && size_ok(grid_size) && size_ok(scle_size);
  assign any_err  = err_data || err_grid || err_scle;
  assign running  = (state == mcu_pkg::GLO_START) || (state == mcu_pkg::GLO_OPERATE);

  always_comb begin
    state_next = state;
    case (state)
      mcu_pkg::GLO_IDLE: begin
        if (operation_start) begin
          state_next = sizes_ok ? mcu_pkg::GLO_START : mcu_pkg::GLO_ERROR;
        end
      end
      mcu_pkg::GLO_START: begin
        state_next = mcu_pkg::GLO_OPERATE;
      end
      mcu_pkg::GLO_OPERATE: begin
        if (&done) begin
          state_next = mcu_pkg::GLO_END;
        end
      end
      mcu_pkg::GLO_END: begin
        state_next = mcu_pkg::GLO_IDLE;
      end
      mcu_pkg::GLO_ERROR: begin
        state_next = mcu_pkg::GLO_IDLE;
      end
      default: begin
        state_next = mcu_pkg::GLO_IDLE;
      end
    endcase
    // A reader fault wins over normal completion
    if (running && any_err) begin
      state_next = mcu_pkg::GLO_ERROR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mcu_pkg::GLO_IDLE;
      done  <= '0;
    end else begin
      state <= state_next;
      if (state == mcu_pkg::GLO_START) begin
        done <= '0;
      end else begin
        done <= done | {last_scle, last_grid, last_data};
      end
    end
  end

  // Transfer sizes captured when a run is requested
  always_ff @(posedge clk) begin
    if ((state == mcu_pkg::GLO_IDLE) && operation_start) begin
      len_data <= data_size;
      len_grid <= grid_size;
      len_scle <= scle_size;
    end
  end

  assign start = (state == mcu_pkg::GLO_START);
  assign abort = (state == mcu_pkg::GLO_ERROR);

  // Status decoded straight from the state register
  assign operation_in_progress = running;
  assign operation_complete    = (state == mcu_pkg::GLO_END);
  assign operation_error       = (state == mcu_pkg::GLO_ERROR);

  // Each stream ends once per run and only while a run is under way
  a_end_in_run: assert property (@(posedge clk) disable iff (rst)
    (last_data || last_grid || last_scle) |->
      ((state == mcu_pkg::GLO_OPERATE) || (state == mcu_pkg::GLO_ERROR)));

  a_end_once: assert property (@(posedge clk) disable iff (rst)
    (({last_scle, last_grid, last_data} & done) == 3'b000));

endmodule

// ==== source/mcu_pkg.sv ====
package mcu_pkg;

  // Memory geometry
  localparam int ADDR_W = 8;

  // One extra bit so a size can cover a full memory
  localparam int SIZE_W = ADDR_W + 1;

  // Largest legal transfer size, sized to compare directly with size inputs
  localparam logic [SIZE_W-1:0] MAX_LEN = 9'd256;

  // Stream word widths
  localparam int DATA_W  = 16;
  localparam int SCALE_W = 8;

  // Buffer free count and reader in-flight count
  localparam int CNT_W = 3;

  // Stream buffer depth
  localparam logic [CNT_W-1:0] FIFO_DEPTH = 3'd4;

  // Global controller states
  typedef enum logic [2:0] {
    GLO_IDLE,
    GLO_START,
    GLO_OPERATE,
    GLO_END,
    GLO_ERROR
  } glo_state_t;

endpackage
